/* list.f */
design/dcache_pkg.sv
design/dcache_array_if.sv
design/dcache_arrays.sv
design/dcache_way_select.sv
design/dcache_ctrl.sv
design/dcache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_dcache.sv

/* Makefile */
# Verilator build and run of the data cache testbench

VERILATOR  ?= verilator
TOP        ?= tb_dcache
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert --timescale 1ns/10ps -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_dcache.sv */
/*
 * testbench of the L1 data cache top level
 * stimulus table, L2 memory model, shadow memory, checks, watchdog
 */

`timescale 1ns/10ps

module tb_dcache;
    localparam int INDEX_W         = 8;
    localparam int TAG_W           = dcache_pkg::ADDR_W - INDEX_W - 2;
    localparam int WORD_W          = dcache_pkg::WORD_W;
    localparam int N_ENTRIES       = 20;
    localparam int REFILL_DELAY    = 3;
    // worst miss with l2 busy and refill delay, with margin
    localparam int MAX_TXN_CYCLES  = 40;
    localparam int WATCHDOG_CYCLES = N_ENTRIES * MAX_TXN_CYCLES + 50;

    localparam logic [TAG_W-1:0]   TAG_A = TAG_W'(32'h00a31);
    localparam logic [TAG_W-1:0]   TAG_B = TAG_W'(32'h01b42);
    localparam logic [TAG_W-1:0]   TAG_C = TAG_W'(32'h02c53);
    localparam logic [TAG_W-1:0]   TAG_D = TAG_W'(32'h03d64);
    localparam logic [TAG_W-1:0]   TAG_E = TAG_W'(32'h04e75);
    localparam logic [TAG_W-1:0]   TAG_F = TAG_W'(32'h05f86);
    localparam logic [INDEX_W-1:0] SET_A = INDEX_W'(5);
    localparam logic [INDEX_W-1:0] SET_B = INDEX_W'(9);

    typedef enum int {
        EXP_HIT,
        EXP_MISS,
        EXP_MISS_WB
    } kind_t;

    typedef logic [dcache_pkg::ADDR_W-3:0] laddr_t;

    logic               clk;
    logic               rst;
    logic               cpu_req;
    logic               cpu_we;
    dcache_pkg::waddr_t cpu_addr;
    dcache_pkg::word_t  cpu_wdata;
    logic               cpu_busy;
    logic               cpu_done;
    dcache_pkg::word_t  cpu_rdata;
    logic               l2_req;
    laddr_t             l2_addr;
    logic               l2_wb;
    laddr_t             l2_wb_addr;
    dcache_pkg::line_t  l2_wb_line;
    logic               l2_busy;
    logic               l2_refill_valid;
    dcache_pkg::line_t  l2_refill_line;

    // stimulus table, one column per array
    logic                tab_we     [N_ENTRIES];
    logic [TAG_W-1:0]    tab_tag    [N_ENTRIES];
    logic [INDEX_W-1:0]  tab_index  [N_ENTRIES];
    dcache_pkg::offset_t tab_offset [N_ENTRIES];
    int                  tab_busy   [N_ENTRIES];
    kind_t               tab_kind   [N_ENTRIES];
    logic [TAG_W-1:0]    tab_wb_tag [N_ENTRIES];
    int                  tab_count;

    logic [31:0]         lfsr_state;
    dcache_pkg::word_t   shadow_mem [dcache_pkg::waddr_t];
    dcache_pkg::line_t   l2_mem [laddr_t];

    // last l2 request seen by the monitor
    int                  l2_req_count;
    laddr_t              last_l2_addr;
    logic                last_l2_wb;
    laddr_t              last_wb_addr;
    dcache_pkg::line_t   last_wb_line;
    dcache_pkg::line_t   pending_line;

    tb_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk          (clk),
        .rst          (rst)
    );

    dcache_top #(
        .INDEX_W         (INDEX_W)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .cpu_req         (cpu_req),
        .cpu_we          (cpu_we),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .cpu_busy        (cpu_busy),
        .cpu_done        (cpu_done),
        .cpu_rdata       (cpu_rdata),
        .l2_req          (l2_req),
        .l2_addr         (l2_addr),
        .l2_wb           (l2_wb),
        .l2_wb_addr      (l2_wb_addr),
        .l2_wb_line      (l2_wb_line),
        .l2_busy         (l2_busy),
        .l2_refill_valid (l2_refill_valid),
        .l2_refill_line  (l2_refill_line)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "stopping at the first failed check");
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_word(output dcache_pkg::word_t w);
        w = '0;
        for (int b = 0; b < WORD_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[WORD_W-2:0], lfsr_state[0]};
        end
    endtask

    // l2 contents before any writeback
    function automatic dcache_pkg::word_t fill_word(input dcache_pkg::waddr_t a);
        return {a, 2'b01} ^ 32'h6b3c_1d5e;
    endfunction

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::waddr_t a);
        if (shadow_mem.exists(a)) begin
            return shadow_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic dcache_pkg::line_t expected_line(input laddr_t la);
        dcache_pkg::line_t data;
        for (int k = 0; k < dcache_pkg::LINE_WORDS; k++) begin
            data[k*WORD_W +: WORD_W] = expected_word({la, 2'(k)});
        end
        return data;
    endfunction

    function automatic dcache_pkg::line_t l2_line(input laddr_t la);
        dcache_pkg::line_t data;
        if (l2_mem.exists(la)) begin
            return l2_mem[la];
        end
        for (int k = 0; k < dcache_pkg::LINE_WORDS; k++) begin
            data[k*WORD_W +: WORD_W] = fill_word({la, 2'(k)});
        end
        return data;
    endfunction

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic add_entry(input logic we, input logic [TAG_W-1:0] tag,
                             input logic [INDEX_W-1:0] index, input dcache_pkg::offset_t offset,
                             input int busy, input kind_t kind,
                             input logic [TAG_W-1:0] wb_tag);
        tab_we[tab_count]     = we;
        tab_tag[tab_count]    = tag;
        tab_index[tab_count]  = index;
        tab_offset[tab_count] = offset;
        tab_busy[tab_count]   = busy;
        tab_kind[tab_count]   = kind;
        tab_wb_tag[tab_count] = wb_tag;
        tab_count++;
    endtask

    task automatic load_table();
        // first fill of set A, then hits
        add_entry(1'b0, TAG_A, SET_A, 2'd0, 0, EXP_MISS, '0);
        add_entry(1'b0, TAG_A, SET_A, 2'd2, 0, EXP_HIT, '0);
        add_entry(1'b1, TAG_A, SET_A, 2'd1, 0, EXP_HIT, '0);
        add_entry(1'b0, TAG_A, SET_A, 2'd1, 0, EXP_HIT, '0);
        // write miss allocates way 1
        add_entry(1'b1, TAG_B, SET_A, 2'd3, 0, EXP_MISS, '0);
        add_entry(1'b0, TAG_B, SET_A, 2'd0, 0, EXP_HIT, '0);
        add_entry(1'b0, TAG_B, SET_A, 2'd3, 0, EXP_HIT, '0);
        // both ways dirty, lru way goes out under l2 busy
        add_entry(1'b0, TAG_C, SET_A, 2'd2, 5, EXP_MISS_WB, TAG_A);
        add_entry(1'b0, TAG_A, SET_A, 2'd1, 0, EXP_MISS_WB, TAG_B);
        add_entry(1'b1, TAG_D, SET_A, 2'd0, 3, EXP_MISS, '0);
        add_entry(1'b0, TAG_D, SET_A, 2'd0, 0, EXP_HIT, '0);
        add_entry(1'b0, TAG_A, SET_A, 2'd1, 0, EXP_HIT, '0);
        add_entry(1'b0, TAG_B, SET_A, 2'd3, 0, EXP_MISS_WB, TAG_D);
        add_entry(1'b0, TAG_F, SET_B, 2'd0, 0, EXP_MISS, '0);
        add_entry(1'b1, TAG_F, SET_B, 2'd3, 0, EXP_HIT, '0);
        add_entry(1'b0, TAG_F, SET_B, 2'd3, 0, EXP_HIT, '0);
        add_entry(1'b1, TAG_B, SET_A, 2'd2, 0, EXP_HIT, '0);
        add_entry(1'b0, TAG_C, SET_A, 2'd2, 0, EXP_MISS, '0);
        add_entry(1'b0, TAG_E, SET_A, 2'd1, 2, EXP_MISS_WB, TAG_B);
        add_entry(1'b0, TAG_B, SET_A, 2'd2, 0, EXP_MISS, '0);
    endtask

    task automatic run_entry(input int i);
        dcache_pkg::waddr_t addr;
        dcache_pkg::word_t  wdata;
        laddr_t             line_addr;
        laddr_t             wb_addr;
        int                 req_base;
        int                 edges;
        logic               done;

        line_addr = {tab_tag[i], tab_index[i]};
        addr      = {line_addr, tab_offset[i]};
        wdata     = '0;
        if (tab_we[i]) begin
            draw_word(wdata);
        end
        req_base = l2_req_count;

        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_we    <= tab_we[i];
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        if (tab_busy[i] > 0) begin
            l2_busy <= 1'b1;
        end
        // request sampled on this edge
        @(posedge clk);
        cpu_req <= 1'b0;
        @(negedge clk);
        assert (cpu_busy)
        else report_error($sformatf("entry %0d: cpu_busy low after acceptance", i));

        edges = 0;
        done  = 1'b0;
        while (!done) begin
            @(posedge clk);
            edges++;
            if (edges == tab_busy[i]) begin
                l2_busy <= 1'b0;
            end
            @(negedge clk);
            done = cpu_done;
            if (!done) begin
                assert (cpu_busy)
                else report_error($sformatf("entry %0d: cpu_busy low before cpu_done", i));
            end
        end
        assert (!cpu_busy)
        else report_error($sformatf("entry %0d: cpu_busy high with cpu_done", i));

        if (tab_kind[i] == EXP_HIT) begin
            assert (edges == 2)
            else report_error($sformatf("entry %0d: hit done after %0d cycles", i, edges));
            assert (l2_req_count == req_base)
            else report_error($sformatf("entry %0d: l2_req issued on a hit", i));
        end else begin
            assert (l2_req_count == req_base + 1)
            else report_error($sformatf("entry %0d: %0d l2 requests on a miss", i,
                                        l2_req_count - req_base));
            assert (last_l2_addr == line_addr)
            else report_error($sformatf("entry %0d: l2_addr %h, expected %h", i,
                                        last_l2_addr, line_addr));
            assert (last_l2_wb == (tab_kind[i] == EXP_MISS_WB))
            else report_error($sformatf("entry %0d: l2_wb is %b", i, last_l2_wb));
            if (tab_kind[i] == EXP_MISS_WB) begin
                wb_addr = {tab_wb_tag[i], tab_index[i]};
                assert (last_wb_addr == wb_addr)
                else report_error($sformatf("entry %0d: l2_wb_addr %h, expected %h", i,
                                            last_wb_addr, wb_addr));
                assert (last_wb_line == expected_line(wb_addr))
                else report_error($sformatf("entry %0d: l2_wb_line %h, expected %h", i,
                                            last_wb_line, expected_line(wb_addr)));
            end
        end

        if (tab_we[i]) begin
            shadow_mem[addr] = wdata;
        end else begin
            assert (cpu_rdata == expected_word(addr))
            else report_error($sformatf("entry %0d: cpu_rdata %h, expected %h", i,
                                        cpu_rdata, expected_word(addr)));
        end
    endtask

    ////////////////////////////////////////
    // L2 model
    ////////////////////////////////////////

    initial begin : l2_request_monitor
        l2_req_count = 0;
        last_l2_addr = '0;
        last_l2_wb   = 1'b0;
        last_wb_addr = '0;
        last_wb_line = '0;
        pending_line = '0;
        forever begin
            @(negedge clk);
            if (!rst && l2_req) begin
                assert (!l2_busy)
                else report_error("l2_req issued while l2_busy is high");
                l2_req_count++;
                last_l2_addr = l2_addr;
                last_l2_wb   = l2_wb;
                last_wb_addr = l2_wb_addr;
                last_wb_line = l2_wb_line;
                if (l2_wb) begin
                    l2_mem[l2_wb_addr] = l2_wb_line;
                end
                pending_line = l2_line(l2_addr);
            end
        end
    end

    // refill pulse a few cycles after each request
    initial begin : l2_refill_driver
        int handled;
        int wait_cycles;
        handled         = 0;
        wait_cycles     = 0;
        l2_refill_valid = 1'b0;
        l2_refill_line  = '0;
        forever begin
            @(posedge clk);
            l2_refill_valid <= 1'b0;
            if (handled != l2_req_count) begin
                handled     = l2_req_count;
                wait_cycles = REFILL_DELAY;
            end else if (wait_cycles > 0) begin
                wait_cycles--;
                if (wait_cycles == 0) begin
                    l2_refill_valid <= 1'b1;
                    l2_refill_line  <= pending_line;
                end
            end
        end
    end

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin : stimulus
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        l2_busy    = 1'b0;
        lfsr_state = 32'h2a18;
        tab_count  = 0;
        load_table();

        @(negedge rst);
        // quiet outputs before the first request
        repeat (3) begin
            @(negedge clk);
            assert (!cpu_busy && !cpu_done && !l2_req && !l2_wb)
            else report_error("outputs active after reset without a request");
        end

        for (int i = 0; i < tab_count; i++) begin
            run_entry(i);
        end

        $display("No errors");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the table did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

/* testbench/tb_clock_gen.sv */
/*
 * clock and reset source of the testbench
 * free-running clock, reset held for a fixed number of cycles
 */

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // released on a rising edge like any other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* design/dcache_top.sv */
/*
 * L1 data cache top level
 * plain cpu and l2 ports, storage and controller
 */

`timescale 1ns/10ps

module dcache_top #(
    parameter int INDEX_W = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    // cpu side
    input  logic                          cpu_req,
    input  logic                          cpu_we,
    input  dcache_pkg::waddr_t            cpu_addr,
    input  dcache_pkg::word_t             cpu_wdata,
    output logic                          cpu_busy,
    output logic                          cpu_done,
    output dcache_pkg::word_t             cpu_rdata,
    // l2 side
    output logic                          l2_req,
    output logic [dcache_pkg::ADDR_W-3:0] l2_addr,
    output logic                          l2_wb,
    output logic [dcache_pkg::ADDR_W-3:0] l2_wb_addr,
    output dcache_pkg::line_t             l2_wb_line,
    input  logic                          l2_busy,
    input  logic                          l2_refill_valid,
    input  dcache_pkg::line_t             l2_refill_line
);

    dcache_array_if #(
        .INDEX_W (INDEX_W)
    ) arr_if ();

    dcache_arrays #(
        .INDEX_W (INDEX_W)
    ) u_arrays (
        .clk     (clk),
        .rst     (rst),
        .arr     (arr_if.array)
    );

    dcache_ctrl #(
        .INDEX_W         (INDEX_W)
    ) u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .arr             (arr_if.ctrl),
        .cpu_req         (cpu_req),
        .cpu_we          (cpu_we),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .cpu_busy        (cpu_busy),
        .cpu_done        (cpu_done),
        .cpu_rdata       (cpu_rdata),
        .l2_req          (l2_req),
        .l2_addr         (l2_addr),
        .l2_wb           (l2_wb),
        .l2_wb_addr      (l2_wb_addr),
        .l2_wb_line      (l2_wb_line),
        .l2_busy         (l2_busy),
        .l2_refill_valid (l2_refill_valid),
        .l2_refill_line  (l2_refill_line)
    );

endmodule

/* design/dcache_ctrl.sv */
/*
 * L1 data cache controller FSM
 * lookup, write hit, miss request with writeback, L2 wait, refill
 */

`timescale 1ns/10ps

module dcache_ctrl #(
    parameter int INDEX_W = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    dcache_array_if.ctrl                  arr,
    // cpu side
    input  logic                          cpu_req,
    input  logic                          cpu_we,
    input  dcache_pkg::waddr_t            cpu_addr,
    input  dcache_pkg::word_t             cpu_wdata,
    output logic                          cpu_busy,
    output logic                          cpu_done,
    output dcache_pkg::word_t             cpu_rdata,
    // l2 side
    output logic                          l2_req,
    output logic [dcache_pkg::ADDR_W-3:0] l2_addr,
    output logic                          l2_wb,
    output logic [dcache_pkg::ADDR_W-3:0] l2_wb_addr,
    output dcache_pkg::line_t             l2_wb_line,
    input  logic                          l2_busy,
    input  logic                          l2_refill_valid,
    input  dcache_pkg::line_t             l2_refill_line
);
    localparam int TAG_W  = dcache_pkg::ADDR_W - INDEX_W - 2;
    localparam int WORD_W = dcache_pkg::WORD_W;

    dcache_pkg::dc_state_t state_q;
    dcache_pkg::dc_state_t state_d;
    // set read in flight, first LOOKUP cycle
    logic                  rd_pend;

    // request held for the whole transaction
    logic [INDEX_W-1:0]    index_q;
    logic [TAG_W-1:0]      tag_q;
    dcache_pkg::offset_t   offset_q;
    logic                  we_q;
    dcache_pkg::word_t     wdata_q;
    dcache_pkg::way_t      victim_way_q;
    dcache_pkg::line_t     refill_q;
    dcache_pkg::line_t     merged_line;

    logic                  accept;
    logic                  compare;
    logic                  hit_done;

    logic                  hit;
    dcache_pkg::way_t      hit_way;
    dcache_pkg::word_t     hit_word;
    dcache_pkg::way_t      victim_way;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    dcache_pkg::line_t     victim_line;

    dcache_way_select #(
        .INDEX_W      (INDEX_W)
    ) u_way_select (
        .cmp_tag      (tag_q),
        .offset       (offset_q),
        .tag0         (arr.tag0),
        .tag1         (arr.tag1),
        .valid0       (arr.valid0),
        .valid1       (arr.valid1),
        .dirty0       (arr.dirty0),
        .dirty1       (arr.dirty1),
        .data0        (arr.data0),
        .data1        (arr.data1),
        .lru          (arr.lru),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line)
    );

    assign accept   = (state_q == dcache_pkg::IDLE) && cpu_req;
    // read data valid, second LOOKUP cycle
    assign compare  = (state_q == dcache_pkg::LOOKUP) && !rd_pend;
    assign hit_done = compare && hit;

    ////////////////////////////////////////
    // storage requests
    ////////////////////////////////////////

    assign arr.rd_en    = rd_pend;
    assign arr.rd_index = index_q;

    // refill of the victim way
    assign arr.line_we  = (state_q == dcache_pkg::REFILL);
    assign arr.wr_way   = victim_way_q;
    assign arr.wr_tag   = tag_q;
    assign arr.wr_line  = refill_q;
    assign arr.wr_dirty = we_q;

    // store on a write hit, lands with cpu_done
    assign arr.word_we     = hit_done && we_q;
    assign arr.word_way    = hit_way;
    assign arr.word_offset = offset_q;
    assign arr.word_data   = wdata_q;

    assign arr.lru_touch = hit_done || arr.line_we;
    assign arr.lru_way   = arr.line_we ? victim_way_q : hit_way;

    ////////////////////////////////////////
    // l2 and cpu outputs
    ////////////////////////////////////////

    // victim data stays in the read registers until the next read
    assign l2_req     = !l2_busy && ((compare && !hit) || (state_q == dcache_pkg::WAIT_L2));
    assign l2_wb      = l2_req && victim_dirty;
    assign l2_addr    = {tag_q, index_q};
    assign l2_wb_addr = {victim_tag, index_q};
    assign l2_wb_line = victim_line;

    assign cpu_busy = (state_q != dcache_pkg::IDLE);

    // store word merged into the returning line
    always_comb begin
        merged_line = l2_refill_line;
        if (we_q) begin
            merged_line[offset_q*WORD_W +: WORD_W] = wdata_q;
        end
    end

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (accept) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit_done) begin
                    state_d = dcache_pkg::IDLE;
                end else if (compare) begin
                    state_d = l2_busy ? dcache_pkg::WAIT_L2 : dcache_pkg::MISS_WAIT;
                end
            end
            dcache_pkg::WAIT_L2: begin
                if (!l2_busy) begin
                    state_d = dcache_pkg::MISS_WAIT;
                end
            end
            dcache_pkg::MISS_WAIT: begin
                if (l2_refill_valid) begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= dcache_pkg::IDLE;
            rd_pend  <= 1'b0;
            cpu_done <= 1'b0;
        end else begin
            state_q  <= state_d;
            rd_pend  <= accept;
            cpu_done <= hit_done || (state_q == dcache_pkg::REFILL);
        end
    end

    // request, victim and refill payload
    always_ff @(posedge clk) begin
        if (accept) begin
            index_q  <= cpu_addr[INDEX_W+1:2];
            tag_q    <= cpu_addr[dcache_pkg::ADDR_W-1:INDEX_W+2];
            offset_q <= cpu_addr[1:0];
            we_q     <= cpu_we;
            wdata_q  <= cpu_wdata;
        end
        if (compare) begin
            victim_way_q <= victim_way;
        end
        if ((state_q == dcache_pkg::MISS_WAIT) && l2_refill_valid) begin
            refill_q <= merged_line;
        end
        if (hit_done) begin
            cpu_rdata <= hit_word;
        end else if (state_q == dcache_pkg::REFILL) begin
            cpu_rdata <= refill_q[offset_q*WORD_W +: WORD_W];
        end
    end

endmodule

/* design/dcache_way_select.sv */
/*
 * hit detection and victim choice over one read-out set
 * word extraction from the hit line
 */

`timescale 1ns/10ps

module dcache_way_select #(
    parameter  int INDEX_W = 8,
    localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - 2
) (
    input  logic [TAG_W-1:0]    cmp_tag,
    input  dcache_pkg::offset_t offset,
    input  logic [TAG_W-1:0]    tag0,
    input  logic [TAG_W-1:0]    tag1,
    input  logic                valid0,
    input  logic                valid1,
    input  logic                dirty0,
    input  logic                dirty1,
    input  dcache_pkg::line_t   data0,
    input  dcache_pkg::line_t   data1,
    input  logic                lru,
    output logic                hit,
    output dcache_pkg::way_t    hit_way,
    output dcache_pkg::word_t   hit_word,
    output dcache_pkg::way_t    victim_way,
    output logic                victim_dirty,
    output logic [TAG_W-1:0]    victim_tag,
    output dcache_pkg::line_t   victim_line
);
    localparam int WORD_W = dcache_pkg::WORD_W;

    logic              hit0;
    logic              hit1;
    dcache_pkg::line_t hit_line;

    ////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////

    assign hit0 = valid0 && (tag0 == cmp_tag);
    assign hit1 = valid1 && (tag1 == cmp_tag);

    assign hit      = hit0 || hit1;
    assign hit_way  = hit1;
    assign hit_line = hit1 ? data1 : data0;
    assign hit_word = hit_line[offset*WORD_W +: WORD_W];

    ////////////////////////////////////////
    // victim
    ////////////////////////////////////////

    // empty way first, lru only when the set is full
    always_comb begin
        if (!valid0) begin
            victim_way = 1'b0;
        end else if (!valid1) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru;
        end
    end

    // stale dirty bits of invalid ways are masked
    assign victim_dirty = victim_way ? (valid1 && dirty1) : (valid0 && dirty0);
    assign victim_tag   = victim_way ? tag1 : tag0;
    assign victim_line  = victim_way ? data1 : data0;

endmodule

/* design/dcache_arrays.sv */
/*
 * tag, valid, dirty, data and lru storage of a two-way cache
 * registered set read, line and word writes
 */

`timescale 1ns/10ps

module dcache_arrays #(
    parameter int INDEX_W = 8
) (
    input logic           clk,
    input logic           rst,
    dcache_array_if.array arr
);
    localparam int TAG_W  = dcache_pkg::ADDR_W - INDEX_W - 2;
    localparam int SETS   = 1 << INDEX_W;
    localparam int WORD_W = dcache_pkg::WORD_W;

    // storage indexed [way][set]
    logic [TAG_W-1:0]  tag_mem   [2][SETS];
    dcache_pkg::line_t data_mem  [2][SETS];
    logic              dirty_mem [2][SETS];

    // per-set valid of each way
    logic [SETS-1:0]   valid_q   [2];
    // names the way to replace next
    logic [SETS-1:0]   lru_q;

    ////////////////////////////////////////
    // valid and lru bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            lru_q      <= '0;
            arr.valid0 <= 1'b0;
            arr.valid1 <= 1'b0;
            arr.lru    <= 1'b0;
        end else begin
            if (arr.line_we) begin
                valid_q[arr.wr_way][arr.rd_index] <= 1'b1;
            end
            // the touched way becomes most recently used
            if (arr.lru_touch) begin
                lru_q[arr.rd_index] <= ~arr.lru_way;
            end
            if (arr.rd_en) begin
                arr.valid0 <= valid_q[0][arr.rd_index];
                arr.valid1 <= valid_q[1][arr.rd_index];
                arr.lru    <= lru_q[arr.rd_index];
            end
        end
    end

    ////////////////////////////////////////
    // tag, data and dirty storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        // store word into the addressed line
        if (arr.word_we) begin
            data_mem[arr.word_way][arr.rd_index][arr.word_offset*WORD_W +: WORD_W]
                <= arr.word_data;
            dirty_mem[arr.word_way][arr.rd_index] <= 1'b1;
        end

        // a line write to the same way takes priority
        if (arr.line_we) begin
            tag_mem[arr.wr_way][arr.rd_index]   <= arr.wr_tag;
            data_mem[arr.wr_way][arr.rd_index]  <= arr.wr_line;
            dirty_mem[arr.wr_way][arr.rd_index] <= arr.wr_dirty;
        end

        // both ways of the set, held until the next read
        if (arr.rd_en) begin
            arr.tag0   <= tag_mem[0][arr.rd_index];
            arr.tag1   <= tag_mem[1][arr.rd_index];
            arr.data0  <= data_mem[0][arr.rd_index];
            arr.data1  <= data_mem[1][arr.rd_index];
            arr.dirty0 <= dirty_mem[0][arr.rd_index];
            arr.dirty1 <= dirty_mem[1][arr.rd_index];
        end
    end

endmodule

/* design/dcache_array_if.sv */
/*
 * connection between cache controller and tag/data storage
 * ctrl modport drives reads and writes, array modport returns the set
 */

`timescale 1ns/10ps

interface dcache_array_if #(
    parameter int INDEX_W = 8
);
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - 2;

    // set read, data shows up one cycle after rd_en
    logic                rd_en;
    // also selects the set for every write
    logic [INDEX_W-1:0]  rd_index;

    // full line write with tag, sets valid
    logic                line_we;
    dcache_pkg::way_t    wr_way;
    logic [TAG_W-1:0]    wr_tag;
    dcache_pkg::line_t   wr_line;
    logic                wr_dirty;

    // single word store, marks the line dirty
    logic                word_we;
    dcache_pkg::way_t    word_way;
    dcache_pkg::offset_t word_offset;
    dcache_pkg::word_t   word_data;

    // lru update, lru then names the other way
    logic                lru_touch;
    dcache_pkg::way_t    lru_way;

    // read-out set
    logic [TAG_W-1:0]    tag0;
    logic [TAG_W-1:0]    tag1;
    logic                valid0;
    logic                valid1;
    logic                dirty0;
    logic                dirty1;
    dcache_pkg::line_t   data0;
    dcache_pkg::line_t   data1;
    logic                lru;

    modport ctrl (
        output rd_en, rd_index,
        output line_we, wr_way, wr_tag, wr_line, wr_dirty,
        output word_we, word_way, word_offset, word_data,
        output lru_touch, lru_way,
        input  tag0, tag1, valid0, valid1, dirty0, dirty1, data0, data1, lru
    );

    modport array (
        input  rd_en, rd_index,
        input  line_we, wr_way, wr_tag, wr_line, wr_dirty,
        input  word_we, word_way, word_offset, word_data,
        input  lru_touch, lru_way,
        output tag0, tag1, valid0, valid1, dirty0, dirty1, data0, data1, lru
    );

endinterface

/* design/dcache_pkg.sv */
/*
 * shared definitions of the L1 data cache
 * address and data widths, vector types, controller states
 */

package dcache_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // cpu word address
    localparam int ADDR_W     = 30;
    localparam int WORD_W     = 32;
    // four words per line
    localparam int LINE_WORDS = 4;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

    // word position inside a line
    typedef logic [1:0]        offset_t;
    typedef logic [ADDR_W-1:0] waddr_t;

    // 0 or 1 in the two-way set
    typedef logic way_t;

    ////////////////////////////////////////
    // controller states
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        // set read, then tag compare
        LOOKUP,
        // miss held back by l2 busy
        WAIT_L2,
        MISS_WAIT,
        REFILL
    } dc_state_t;

endpackage
